/* all.f */
common/arb_pkg.sv
common/arb_req_if.sv
arbiter/hold_timer.sv
arbiter/rr_selector.sv
arbiter/bus_controller.sv
design/bus_crossbar.sv
design/bus_arbiter_top.sv
sim/tb_bus_arbiter.sv

/* arbiter/bus_controller.sv */
`timescale 1ns/10ps

module bus_controller (
  input  logic                          clk,
  input  logic                          rstN,
  arb_req_if.ctrl                       req,
  input  logic                          request,
  input  logic [arb_pkg::MASTER_ID_W-1:0] next_master,
  input  logic [arb_pkg::SLAVE_ID_W-1:0]  next_slave,
  input  logic                          limit_hit,
  output logic [arb_pkg::MASTER_ID_W-1:0] last_master,
  output logic                          hold_run,
  output logic                          hold_clear,
  output arb_pkg::bus_grant_t           grant
);
  import arb_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    ALLOC,
    ACK,
    COM,
    DONE,
    OVER
  } state_t;

  state_t state;
  state_t next_state;

  logic [MASTER_ID_W-1:0] cur_master;
  logic [SLAVE_ID_W-1:0]  cur_slave;
  cmd_t                   cur_cmd;
  com_t                   cur_com_state;
  logic                   cur_done;
  logic                   split_pending;
  logic                   split_now;

  ////////////////////
  // master side
  ////////////////////

  assign cur_com_state = req.com_state[cur_master];
  assign cur_done      = req.done[cur_master];

  // only the current master sees a command
  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      if (MASTER_ID_W'(i) == cur_master) begin
        req.cmd[i] = cur_cmd;
      end else begin
        req.cmd[i] = CMD_WAIT;
      end
    end
  end

  // competing request from another master once the hold limit is reached
  assign split_now = limit_hit && request && (next_master != cur_master);

  // the latched master is also the last one served
  assign last_master = cur_master;

  // timer restarts with every allocation, runs while the bus is held
  assign hold_clear = (state == ALLOC);
  assign hold_run   = (state == COM);

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (request) begin
          next_state = ALLOC;
        end
      end
      ALLOC: next_state = ACK;
      ACK: begin
        if (cur_com_state == COM_ACTIVE) begin
          next_state = COM;
        end else if (cur_com_state == COM_NAK) begin
          next_state = IDLE;
        end
      end
      COM: begin
        // a finished transfer wins over a split in the same cycle
        if (cur_com_state == COM_END) begin
          next_state = OVER;
        end else if (split_now) begin
          next_state = DONE;
        end
      end
      DONE: begin
        if (cur_done) begin
          next_state = OVER;
        end
      end
      OVER: begin
        if (split_pending && request) begin
          next_state = ALLOC;
        end else begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  ////////////////////
  // grant and command
  ////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      cur_master    <= '0;
      cur_slave     <= '0;
      cur_cmd       <= CMD_WAIT;
      grant         <= '0;
      split_pending <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (request) begin
            cur_master <= next_master;
            cur_slave  <= next_slave;
          end
        end
        ALLOC: begin
          cur_cmd <= CMD_CLEAR;
        end
        ACK: begin
          if (cur_com_state == COM_ACTIVE) begin
            grant.master <= cur_master;
            grant.slave  <= cur_slave;
          end else if (cur_com_state == COM_NAK) begin
            grant   <= '0;
            cur_cmd <= CMD_WAIT;
          end
        end
        COM: begin
          if (cur_com_state == COM_END) begin
            grant   <= '0;
            cur_cmd <= CMD_WAIT;
          end else if (split_now) begin
            cur_cmd <= CMD_STOP;
          end
        end
        DONE: begin
          // master has let go, free the lines before the next owner
          if (cur_done) begin
            grant         <= '0;
            cur_cmd       <= CMD_WAIT;
            split_pending <= 1'b1;
          end
        end
        OVER: begin
          split_pending <= 1'b0;
          if (split_pending && request) begin
            cur_master <= next_master;
            cur_slave  <= next_slave;
          end
        end
        default: begin
          grant   <= '0;
          cur_cmd <= CMD_WAIT;
        end
      endcase
    end
  end

endmodule

/* arbiter/hold_timer.sv */
`timescale 1ns/10ps

module hold_timer (
  input  logic clk,
  input  logic rstN,
  input  logic run,
  input  logic clear,
  output logic limit_hit
);
  import arb_pkg::*;

  logic [HOLD_CNT_W-1:0] hold_cnt;
  logic                  at_limit;

  assign at_limit = (hold_cnt == HOLD_CNT_W'(HOLD_LIMIT));

  // saturating count of cycles held by the current master
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      hold_cnt  <= '0;
      limit_hit <= 1'b0;
    end else if (clear) begin
      hold_cnt  <= '0;
      limit_hit <= 1'b0;
    end else if (run && !at_limit) begin
      hold_cnt  <= hold_cnt + 1'b1;
      // flag lands together with the final count
      limit_hit <= (hold_cnt == HOLD_CNT_W'(HOLD_LIMIT - 1));
    end
  end

endmodule

/* arbiter/rr_selector.sv */
`timescale 1ns/10ps

module rr_selector (
  arb_req_if.sel                          req,
  input  logic [arb_pkg::MASTER_ID_W-1:0] last_master,
  output logic                            request,
  output logic [arb_pkg::MASTER_ID_W-1:0] next_master,
  output logic [arb_pkg::SLAVE_ID_W-1:0]  next_slave
);
  import arb_pkg::*;

  logic [NUM_MASTERS-1:0] asking;

  ////////////////////
  // active requests
  ////////////////////

  always_comb begin
    for (int i = 0; i < NUM_MASTERS; i++) begin
      asking[i] = (req.id[i] != '0);
    end
  end

  assign request = |asking;

  ////////////////////
  // round-robin scan
  ////////////////////

  // start one past the last master served and wrap around,
  // so the last master only wins when nobody else asks
  always_comb begin
    int unsigned idx;
    logic        found;
    found       = 1'b0;
    next_master = last_master;
    next_slave  = '0;
    for (int k = 1; k <= NUM_MASTERS; k++) begin
      idx = (int'(last_master) + k) % NUM_MASTERS;
      if (!found && asking[idx]) begin
        found       = 1'b1;
        next_master = MASTER_ID_W'(idx);
        next_slave  = req.id[idx];
      end
    end
  end

endmodule

/* common/arb_pkg.sv */
package arb_pkg;

  ////////////////////
  // bus sizes
  ////////////////////

  localparam int NUM_MASTERS = 2;
  localparam int NUM_SLAVES  = 3;

  // slave id zero means no request or no target
  localparam int SLAVE_ID_W  = 2;
  localparam int MASTER_ID_W = 1;

  ////////////////////
  // hold threshold
  ////////////////////

  // held cycles before a waiting master may split the transfer
  localparam int HOLD_LIMIT = 16;
  localparam int HOLD_CNT_W = $clog2(HOLD_LIMIT + 1);

  ////////////////////
  // encodings
  ////////////////////

  // arbiter to master
  typedef enum logic [1:0] {
    CMD_WAIT  = 2'b00,
    CMD_STOP  = 2'b01,
    CMD_CLEAR = 2'b11
  } cmd_t;

  // master to arbiter handshake word
  typedef enum logic [1:0] {
    COM_END      = 2'b00,
    COM_NAK      = 2'b01,
    COM_WAIT_ACK = 2'b10,
    COM_ACTIVE   = 2'b11
  } com_t;

  // current owner of the bus, slave zero when idle
  typedef struct packed {
    logic [MASTER_ID_W-1:0] master;
    logic [SLAVE_ID_W-1:0]  slave;
  } bus_grant_t;

endpackage

/* common/arb_req_if.sv */
`timescale 1ns/10ps

interface arb_req_if;
  import arb_pkg::*;

  // one entry per master
  logic [SLAVE_ID_W-1:0]  id [NUM_MASTERS];
  com_t                   com_state [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] done;
  cmd_t                   cmd [NUM_MASTERS];

  // handshake side, used by the bus controller
  modport ctrl (
    input  com_state,
    input  done,
    output cmd
  );

  // request side, used by the round-robin selector
  modport sel (
    input id
  );

endinterface

/* design/bus_arbiter_top.sv */
`timescale 1ns/10ps

module bus_arbiter_top (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic [arb_pkg::SLAVE_ID_W-1:0]  id [arb_pkg::NUM_MASTERS],
  input  arb_pkg::com_t                   com_state [arb_pkg::NUM_MASTERS],
  input  logic [arb_pkg::NUM_MASTERS-1:0] done,
  output arb_pkg::cmd_t                   cmd [arb_pkg::NUM_MASTERS],
  input  logic [arb_pkg::NUM_MASTERS-1:0] m_addr,
  input  logic [arb_pkg::NUM_MASTERS-1:0] m_mosi,
  input  logic [arb_pkg::NUM_MASTERS-1:0] m_valid,
  input  logic [arb_pkg::NUM_MASTERS-1:0] m_last,
  output logic [arb_pkg::NUM_MASTERS-1:0] m_miso,
  output logic [arb_pkg::NUM_MASTERS-1:0] m_ready,
  output logic [arb_pkg::NUM_SLAVES-1:0]  s_addr,
  output logic [arb_pkg::NUM_SLAVES-1:0]  s_mosi,
  output logic [arb_pkg::NUM_SLAVES-1:0]  s_valid,
  output logic [arb_pkg::NUM_SLAVES-1:0]  s_last,
  input  logic [arb_pkg::NUM_SLAVES-1:0]  s_miso,
  input  logic [arb_pkg::NUM_SLAVES-1:0]  s_ready
);
  import arb_pkg::*;

  arb_req_if req_bus ();

  logic                   request;
  logic [MASTER_ID_W-1:0] next_master;
  logic [SLAVE_ID_W-1:0]  next_slave;
  logic [MASTER_ID_W-1:0] last_master;
  logic                   hold_run;
  logic                   hold_clear;
  logic                   limit_hit;
  bus_grant_t             grant;

  ////////////////////
  // master request side
  ////////////////////

  assign req_bus.id        = id;
  assign req_bus.com_state = com_state;
  assign req_bus.done      = done;
  assign cmd               = req_bus.cmd;

  ////////////////////
  // arbitration
  ////////////////////

  rr_selector u_sel (
    .req         (req_bus.sel),
    .last_master (last_master),
    .request     (request),
    .next_master (next_master),
    .next_slave  (next_slave)
  );

  hold_timer u_timer (
    .clk       (clk),
    .rstN      (rstN),
    .run       (hold_run),
    .clear     (hold_clear),
    .limit_hit (limit_hit)
  );

  bus_controller u_ctrl (
    .clk         (clk),
    .rstN        (rstN),
    .req         (req_bus.ctrl),
    .request     (request),
    .next_master (next_master),
    .next_slave  (next_slave),
    .limit_hit   (limit_hit),
    .last_master (last_master),
    .hold_run    (hold_run),
    .hold_clear  (hold_clear),
    .grant       (grant)
  );

  // serial lines follow the grant with no added cycle
  bus_crossbar u_xbar (
    .grant   (grant),
    .m_addr  (m_addr),
    .m_mosi  (m_mosi),
    .m_valid (m_valid),
    .m_last  (m_last),
    .s_addr  (s_addr),
    .s_mosi  (s_mosi),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_miso  (s_miso),
    .s_ready (s_ready),
    .m_miso  (m_miso),
    .m_ready (m_ready)
  );

endmodule

/* design/bus_crossbar.sv */
`timescale 1ns/10ps

module bus_crossbar (
  input  arb_pkg::bus_grant_t              grant,
  input  logic [arb_pkg::NUM_MASTERS-1:0]  m_addr,
  input  logic [arb_pkg::NUM_MASTERS-1:0]  m_mosi,
  input  logic [arb_pkg::NUM_MASTERS-1:0]  m_valid,
  input  logic [arb_pkg::NUM_MASTERS-1:0]  m_last,
  output logic [arb_pkg::NUM_SLAVES-1:0]   s_addr,
  output logic [arb_pkg::NUM_SLAVES-1:0]   s_mosi,
  output logic [arb_pkg::NUM_SLAVES-1:0]   s_valid,
  output logic [arb_pkg::NUM_SLAVES-1:0]   s_last,
  input  logic [arb_pkg::NUM_SLAVES-1:0]   s_miso,
  input  logic [arb_pkg::NUM_SLAVES-1:0]   s_ready,
  output logic [arb_pkg::NUM_MASTERS-1:0]  m_miso,
  output logic [arb_pkg::NUM_MASTERS-1:0]  m_ready
);
  import arb_pkg::*;

  logic [SLAVE_ID_W-1:0] slave_sel;

  // slave ids start at one
  assign slave_sel = grant.slave - 1'b1;

  ////////////////////
  // master to slave
  ////////////////////

  always_comb begin
    s_addr  = '0;
    s_mosi  = '0;
    s_valid = '0;
    s_last  = '0;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      if (grant.slave == SLAVE_ID_W'(s + 1)) begin
        s_addr[s]  = m_addr[grant.master];
        s_mosi[s]  = m_mosi[grant.master];
        s_valid[s] = m_valid[grant.master];
        s_last[s]  = m_last[grant.master];
      end
    end
  end

  ////////////////////
  // slave to master
  ////////////////////

  // idle grant returns zeros to every master
  always_comb begin
    m_miso  = '0;
    m_ready = '0;
    if (grant.slave != '0) begin
      m_miso[grant.master]  = s_miso[slave_sel];
      m_ready[grant.master] = s_ready[slave_sel];
    end
  end

endmodule

/* sim/arb_testdata.txt */
# columns: name id0 resp0 len0 id1 resp1 len1 first second stop0 stop1
# id 0 is no request; first and second are expected granted masters, -1 for none
single_grant    2 ack  4  0 -    0  0 -1 0 0
nak_lone        0 -    0  3 nak  0  1 -1 0 0
rr_both         1 ack  3  3 ack  3  0  1 0 0
lone_m0         1 ack  2  0 -    0  0 -1 0 0
rr_swap         2 ack  2  1 ack  3  1  0 0 0
split_m1        3 ack  3  2 ack 24  1  0 0 1
long_alone      0 -    0  3 ack 22  1 -1 0 0
split_m0        1 ack 30  2 ack 20  0  1 1 0
nak_both        3 nak  0  1 ack  2  0  1 0 0
lone_slave3     3 ack  5  0 -    0  0 -1 0 0
rr_again        2 ack  4  3 ack  4  1  0 0 0
nak_then_long   1 ack 25  2 nak  0  1  0 0 0

/* sim/tb_bus_arbiter.sv */
`timescale 1ns/10ps

module tb_bus_arbiter;
  import arb_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;

  logic                   clk;
  logic                   rstN;
  logic [SLAVE_ID_W-1:0]  id [NUM_MASTERS];
  com_t                   com_state [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] done;
  cmd_t                   cmd [NUM_MASTERS];
  logic [NUM_MASTERS-1:0] m_addr;
  logic [NUM_MASTERS-1:0] m_mosi;
  logic [NUM_MASTERS-1:0] m_valid;
  logic [NUM_MASTERS-1:0] m_last;
  logic [NUM_MASTERS-1:0] m_miso;
  logic [NUM_MASTERS-1:0] m_ready;
  logic [NUM_SLAVES-1:0]  s_addr;
  logic [NUM_SLAVES-1:0]  s_mosi;
  logic [NUM_SLAVES-1:0]  s_valid;
  logic [NUM_SLAVES-1:0]  s_last;
  logic [NUM_SLAVES-1:0]  s_miso;
  logic [NUM_SLAVES-1:0]  s_ready;

  int seed = 23124;
  int grant_order[$];
  bit stopped [NUM_MASTERS];
  int scen_count;

  bus_arbiter_top dut (
    .clk       (clk),
    .rstN      (rstN),
    .id        (id),
    .com_state (com_state),
    .done      (done),
    .cmd       (cmd),
    .m_addr    (m_addr),
    .m_mosi    (m_mosi),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_miso    (m_miso),
    .m_ready   (m_ready),
    .s_addr    (s_addr),
    .s_mosi    (s_mosi),
    .s_valid   (s_valid),
    .s_last    (s_last),
    .s_miso    (s_miso),
    .s_ready   (s_ready)
  );

  always #5 clk = ~clk;

  // slave models answer with random miso and ready bits
  always @(negedge clk) begin
    s_miso  = NUM_SLAVES'($random(seed));
    s_ready = NUM_SLAVES'($random(seed));
  end

  ////////////////////
  // checks
  ////////////////////

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      stop_on_error($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
    end
  endtask

  task automatic wait_for_cmd(input int m, input cmd_t value, input string what);
    for (int t = 0; t < TIMEOUT_CYCLES; t++) begin
      @(negedge clk);
      if (cmd[m] == value) begin
        return;
      end
    end
    stop_on_error($sformatf("timeout: master %0d never received %s", m, what));
  endtask

  // sid zero means no slave may see anything and no master gets an answer
  task automatic check_routing(input string name, input int m, input int sid);
    logic [3:0] exp_fwd;
    logic [1:0] exp_back;
    for (int s = 0; s < NUM_SLAVES; s++) begin
      exp_fwd = (s + 1 == sid) ? {m_addr[m], m_mosi[m], m_valid[m], m_last[m]} : 4'b0;
      check_val($sformatf("%s slave %0d lines", name, s + 1), exp_fwd,
                {s_addr[s], s_mosi[s], s_valid[s], s_last[s]});
    end
    for (int k = 0; k < NUM_MASTERS; k++) begin
      exp_back = (k == m && sid != 0) ? {s_miso[sid-1], s_ready[sid-1]} : 2'b0;
      check_val($sformatf("%s master %0d miso and ready", name, k), exp_back,
                {m_miso[k], m_ready[k]});
    end
  endtask

  ////////////////////
  // master model
  ////////////////////

  task automatic play_master(input string name, input int m, input int sid, input bit nak,
                             input int len);
    string tag;
    bit    got_wait;
    tag = $sformatf("%s m%0d", name, m);
    if (sid == 0) begin
      return;
    end
    id[m] = SLAVE_ID_W'(sid);
    wait_for_cmd(m, CMD_CLEAR, "CMD_CLEAR after its request");
    grant_order.push_back(m);
    @(negedge clk);
    com_state[m] = COM_WAIT_ACK;
    @(negedge clk);
    if (nak) begin
      com_state[m] = COM_NAK;
      // lines held high, none of it may reach a slave
      m_addr[m]  = 1'b1;
      m_mosi[m]  = 1'b1;
      m_valid[m] = 1'b1;
      m_last[m]  = 1'b1;
      got_wait   = 1'b0;
      for (int t = 0; t < TIMEOUT_CYCLES && !got_wait; t++) begin
        // look after the edge that answers the nak
        @(posedge clk);
        #1;
        check_routing({tag, " nak"}, m, 0);
        @(negedge clk);
        got_wait = (cmd[m] == CMD_WAIT);
      end
      if (!got_wait) begin
        stop_on_error($sformatf("timeout: master %0d never got CMD_WAIT after nak", m));
      end
    end else begin
      com_state[m] = COM_ACTIVE;
      for (int c = 0; c <= len && !stopped[m]; c++) begin
        @(negedge clk);
        if (cmd[m] == CMD_STOP) begin
          stopped[m] = 1'b1;
        end else if (c < len) begin
          check_val({tag, " cmd during transfer"}, CMD_CLEAR, cmd[m]);
          m_addr[m]  = 1'($random(seed));
          m_mosi[m]  = 1'($random(seed));
          m_valid[m] = 1'b1;
          m_last[m]  = (c == len - 1);
          #1;
          check_routing(tag, m, sid);
        end
      end
    end
    m_addr[m]  = 1'b0;
    m_mosi[m]  = 1'b0;
    m_valid[m] = 1'b0;
    m_last[m]  = 1'b0;
    // split: raise done and hold it until the arbiter lets go
    if (stopped[m]) begin
      done[m] = 1'b1;
      wait_for_cmd(m, CMD_WAIT, "CMD_WAIT after raising done");
      done[m] = 1'b0;
    end
    com_state[m] = COM_END;
    id[m]        = '0;
    if (!nak && !stopped[m]) begin
      wait_for_cmd(m, CMD_WAIT, "CMD_WAIT after COM_END");
    end
  endtask

  ////////////////////
  // scenario player
  ////////////////////

  task automatic play_scenario(input string name, input int id0, input bit nak0, input int len0,
                               input int id1, input bit nak1, input int len1, input int first,
                               input int second, input int st0, input int st1);
    int n_exp;
    grant_order.delete();
    stopped[0] = 1'b0;
    stopped[1] = 1'b0;
    @(negedge clk);
    fork
      play_master(name, 0, id0, nak0, len0);
      play_master(name, 1, id1, nak1, len1);
    join
    n_exp = (first >= 0) + (second >= 0);
    check_val({name, " grant count"}, n_exp, grant_order.size());
    if (first >= 0) begin
      check_val({name, " first grant"}, first, grant_order[0]);
    end
    if (second >= 0) begin
      check_val({name, " second grant"}, second, grant_order[1]);
    end
    check_val({name, " master 0 stopped"}, st0, stopped[0]);
    check_val({name, " master 1 stopped"}, st1, stopped[1]);
    $display("scenario %s done", name);
    repeat (3) @(negedge clk);
  endtask

  initial begin
    int    fd;
    int    got;
    int    n_fields;
    string line;
    string name;
    string resp0;
    string resp1;
    int    id0;
    int    len0;
    int    id1;
    int    len1;
    int    first;
    int    second;
    int    st0;
    int    st1;
    clk     = 1'b0;
    rstN    = 1'b0;
    done    = '0;
    // master lines high through reset, a stray grant would show on a slave
    m_addr  = '1;
    m_mosi  = '1;
    m_valid = '1;
    m_last  = '1;
    s_miso  = '0;
    s_ready = '0;
    for (int m = 0; m < NUM_MASTERS; m++) begin
      id[m]        = '0;
      com_state[m] = COM_END;
    end
    scen_count = 0;
    repeat (2) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);
    for (int m = 0; m < NUM_MASTERS; m++) begin
      check_val($sformatf("reset cmd m%0d", m), CMD_WAIT, cmd[m]);
    end
    check_val("reset slave lines", 0, {s_addr, s_mosi, s_valid, s_last});
    m_addr  = '0;
    m_mosi  = '0;
    m_valid = '0;
    m_last  = '0;

    fd = $fopen("sim/arb_testdata.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open the data file sim/arb_testdata.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      got  = $fgets(line, fd);
      if (got == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n_fields = $sscanf(line, "%s %d %s %d %d %s %d %d %d %d %d", name, id0, resp0, len0,
                         id1, resp1, len1, first, second, st0, st1);
      if (n_fields != 11) begin
        stop_on_error({"malformed line in the data file: ", line});
      end
      play_scenario(name, id0, resp0 == "nak", len0, id1, resp1 == "nak", len1,
                    first, second, st0, st1);
      scen_count++;
    end
    $fclose(fd);

    if (scen_count == 0) begin
      stop_on_error("no scenario was read from the data file");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule
